// ==== bench/cacheInput.txt ====
# name opm addr wrData expData ok ddrCmds latency, every field but the name in hex
# opm 00 makes no request and compares the last DDR write, latency 0 means any
rdMiss    17 01000040 00000000000000000000000000000000 01000040FEFFFFBF01000040FEFFFFBF 1 1 0
rdHit     17 01000040 00000000000000000000000000000000 01000040FEFFFFBF01000040FEFFFFBF 1 0 1
wrTile    1f 01000080 0123456789ABCDEF0F1E2D3C4B5A6978 00000000000000000000000000000000 1 0 1
rdAfterWr 17 01000080 00000000000000000000000000000000 0123456789ABCDEF0F1E2D3C4B5A6978 1 0 1
rdWb      17 02000080 00000000000000000000000000000000 02000080FDFFFF7F02000080FDFFFF7F 1 2 0
wbCheck   00 01000080 00000000000000000000000000000000 0123456789ABCDEF0F1E2D3C4B5A6978 0 0 0
rdWbHit   17 02000080 00000000000000000000000000000000 02000080FDFFFF7F02000080FDFFFF7F 1 0 1
rdBack    17 01000080 00000000000000000000000000000000 0123456789ABCDEF0F1E2D3C4B5A6978 1 1 0
wrClean   1f 03000080 DEADBEEF00112233445566778899AABB 00000000000000000000000000000000 1 0 1
wrVictim  1f 01000080 CAFEF00D13579BDF2468ACE0FEDCBA98 00000000000000000000000000000000 1 1 0
wbCheck2  00 03000080 00000000000000000000000000000000 DEADBEEF00112233445566778899AABB 0 0 0
rdVictim  17 01000080 00000000000000000000000000000000 CAFEF00D13579BDF2468ACE0FEDCBA98 1 0 1
rdOld     17 03000080 00000000000000000000000000000000 DEADBEEF00112233445566778899AABB 1 2 0
wbCheck3  00 01000080 00000000000000000000000000000000 CAFEF00D13579BDF2468ACE0FEDCBA98 0 0 0
nonRamHi  17 40000080 00000000000000000000000000000000 00000000000000000000000000000000 0 0 0
nonRamLo  17 00000200 00000000000000000000000000000000 00000000000000000000000000000000 0 0 0
nonRamWr  1f 80000080 DEADBEEF00112233445566778899AABB 00000000000000000000000000000000 0 0 0
rdOldHit  17 03000080 00000000000000000000000000000000 DEADBEEF00112233445566778899AABB 1 0 1
stress1   17 01000100 00000000000000000000000000000000 01000100FEFFFEFF01000100FEFFFEFF 1 1 0
stress2   17 01000200 00000000000000000000000000000000 01000200FEFFFDFF01000200FEFFFDFF 1 1 0
stress3   17 05000300 00000000000000000000000000000000 05000300FAFFFCFF05000300FAFFFCFF 1 1 0
stress4   17 3f000ff0 00000000000000000000000000000000 3F000FF0C0FFF00F3F000FF0C0FFF00F 1 1 0
stress5   17 02000100 00000000000000000000000000000000 02000100FDFFFEFF02000100FDFFFEFF 1 1 0
stress6   17 01000100 00000000000000000000000000000000 01000100FEFFFEFF01000100FEFFFEFF 1 1 0
stress7   17 3f000ff0 00000000000000000000000000000000 3F000FF0C0FFF00F3F000FF0C0FFF00F 1 0 1
stress8   17 05000300 00000000000000000000000000000000 05000300FAFFFCFF05000300FAFFFCFF 1 0 1
stress9   1f 05000300 CAFEF00D13579BDF2468ACE0FEDCBA98 00000000000000000000000000000000 1 0 1
stress10  17 05000300 00000000000000000000000000000000 CAFEF00D13579BDF2468ACE0FEDCBA98 1 0 1
stress11  17 02000200 00000000000000000000000000000000 02000200FDFFFDFF02000200FDFFFDFF 1 1 0
stress12  17 01000200 00000000000000000000000000000000 01000200FEFFFDFF01000200FEFFFDFF 1 1 0
stress13  17 06000300 00000000000000000000000000000000 06000300F9FFFCFF06000300F9FFFCFF 1 2 0
wbCheck4  00 05000300 00000000000000000000000000000000 CAFEF00D13579BDF2468ACE0FEDCBA98 0 0 0
stress14  17 05000300 00000000000000000000000000000000 CAFEF00D13579BDF2468ACE0FEDCBA98 1 1 0

// ==== list.f ====
logic/memPkg.sv
logic/tileLookupStage.sv
logic/tileHitStage.sv
logic/tileRefillSeq.sv
logic/l2TileCache.sv
bench/ddrTileModel.sv
bench/l2TileCacheBench.sv

// ==== Bender.yml ====
package:
  name: l2tilecache

sources:
  # RTL, package first
  - logic/memPkg.sv
  - logic/tileLookupStage.sv
  - logic/tileHitStage.sv
  - logic/tileRefillSeq.sv
  - logic/l2TileCache.sv

  # testbench with the behavioral DDR model
  - target: simulation
    files:
      - bench/ddrTileModel.sv
      - bench/l2TileCacheBench.sv

// ==== bench/l2TileCacheBench.sv ====
`timescale 1ns/1ps

module l2TileCacheBench;

	localparam int timeoutCycles = 200;

	logic clock = 1'b0;
	logic rstN;

	memPkg::byteAddrT memAddr;
	memPkg::opmT memOpm;
	memPkg::tileT memDataIn;
	memPkg::tileT memDataOut;
	memPkg::okT memOk;

	memPkg::byteAddrT ddrAddr;
	memPkg::opmT ddrOpm;
	memPkg::tileT ddrDataOut;
	memPkg::tileT ddrDataIn;
	memPkg::okT ddrOk;

	memPkg::byteAddrT wrAddrSeen;
	memPkg::tileT wrDataSeen;
	logic [1:0] holdPick = 2'd2;
	logic [1:0] nextPick;
	logic [31:0] lfsrState = 32'hdc03;

	// port monitor state
	int ddrCmdCount = 0;
	int holdErrors = 0;
	int holdCycles = 0;
	memPkg::okT lastOk = memPkg::okReady;
	memPkg::opmT lastOpm;
	memPkg::byteAddrT lastAddr;

	int errorCount = 0;
	int testCount = 0;
	int failCount = 0;
	logic testFailed;
	logic stopRun = 1'b0;

	// one line of the stimulus file
	int fd;
	int fields;
	logic [8*128-1:0] lineBuf;
	logic [8*16-1:0] testName;
	memPkg::opmT opm;
	memPkg::byteAddrT addr;
	memPkg::tileT wrData;
	memPkg::tileT expData;
	memPkg::okT expOk;
	int expCmds;
	int expLat;

	memPkg::okT okSeen;
	memPkg::tileT rdData;
	int cycles;
	int cmds;
	logic timedOut;

	l2TileCache #(
		.indexBits(10)
	) UUT (
		.clock(clock),
		.rstN(rstN),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.memDataIn(memDataIn),
		.memDataOut(memDataOut),
		.memOk(memOk),
		.ddrAddr(ddrAddr),
		.ddrOpm(ddrOpm),
		.ddrDataOut(ddrDataOut),
		.ddrDataIn(ddrDataIn),
		.ddrOk(ddrOk)
	);

	ddrTileModel ddr (
		.clock(clock),
		.rstN(rstN),
		.ddrAddr(ddrAddr),
		.ddrOpm(ddrOpm),
		.ddrDataOut(ddrDataOut),
		.holdPick(holdPick),
		.ddrDataIn(ddrDataIn),
		.ddrOk(ddrOk),
		.lastWrAddr(wrAddrSeen),
		.lastWrData(wrDataSeen)
	);

	always #50 clock = ~clock;

	// *************************************************************************
	// random hold cycles and DDR port monitor
	// *************************************************************************

	// taps 32 22 2 1
	function automatic logic nextRandomBit();
		logic feedback;
		feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], feedback};
		return feedback;
	endfunction

	// a fresh hold count for every command the model accepts
	always @(posedge clock)
	begin
		if (rstN && ddrOk == memPkg::okReady && ddrOpm != memPkg::opmReady)
		begin
			nextPick[1] = nextRandomBit();
			nextPick[0] = nextRandomBit();
			holdPick <= nextPick;
			ddrCmdCount <= ddrCmdCount + 1;
		end
	end

	always @(negedge clock)
	begin
		if (rstN && lastOk == memPkg::okHold && (ddrOpm != lastOpm || ddrAddr != lastAddr))
		begin
			$display("DDR command changed while the model held it");
			holdErrors++;
		end
		if (ddrOk == memPkg::okHold)
			holdCycles++;
		lastOk = ddrOk;
		lastOpm = ddrOpm;
		lastAddr = ddrAddr;
	end

	// *************************************************************************
	// compare tasks
	// *************************************************************************

	task automatic checkTile(input string sigName, input memPkg::tileT got,
		input memPkg::tileT exp);
		if (got !== exp)
		begin
			$display("FAILED %s got %h expected %h", sigName, got, exp);
			errorCount++;
			testFailed = 1'b1;
		end
	endtask

	task automatic checkOk(input string sigName, input memPkg::okT got, input memPkg::okT exp);
		if (got !== exp)
		begin
			$display("FAILED %s got %h expected %h", sigName, got, exp);
			errorCount++;
			testFailed = 1'b1;
		end
	endtask

	task automatic checkAddr(input string sigName, input memPkg::byteAddrT got,
		input memPkg::byteAddrT exp);
		if (got !== exp)
		begin
			$display("FAILED %s got %h expected %h", sigName, got, exp);
			errorCount++;
			testFailed = 1'b1;
		end
	endtask

	task automatic checkOpm(input string sigName, input memPkg::opmT got, input memPkg::opmT exp);
		if (got !== exp)
		begin
			$display("FAILED %s got %h expected %h", sigName, got, exp);
			errorCount++;
			testFailed = 1'b1;
		end
	endtask

	task automatic checkCount(input string sigName, input int got, input int exp);
		if (got != exp)
		begin
			$display("FAILED %s got %h expected %h", sigName, got, exp);
			errorCount++;
			testFailed = 1'b1;
		end
	endtask

	task automatic reportTest(input logic [8*16-1:0] name);
		testCount++;
		if (testFailed)
		begin
			failCount++;
			$display("test %0s: fail", name);
		end
		else
			$display("test %0s: pass", name);
	endtask

	// *************************************************************************
	// request driver
	// *************************************************************************

	// called just after a rising edge, returns in the ok cycle
	task automatic runRequest(input memPkg::opmT reqOpm, input memPkg::byteAddrT reqAddr,
		input memPkg::tileT reqData);
		int cmdStart;
		cmdStart = ddrCmdCount;
		memOpm = reqOpm;
		memAddr = reqAddr;
		memDataIn = reqData;
		cycles = 0;
		timedOut = 1'b0;
		okSeen = memPkg::okHold;
		while (okSeen == memPkg::okHold && !timedOut)
		begin
			@(posedge clock);
			#5;
			cycles++;
			okSeen = memOk;
			if (okSeen == memPkg::okHold && cycles >= timeoutCycles)
				timedOut = 1'b1;
		end
		rdData = memDataOut;
		cmds = ddrCmdCount - cmdStart;
		memOpm = memPkg::opmReady;
		memAddr = '0;
		memDataIn = '0;
	endtask

	task automatic runLine();
		testFailed = 1'b0;
		if (opm == memPkg::opmReady)
		begin
			// no request, look at the last DDR write instead
			checkAddr("ddrAddr", wrAddrSeen, addr);
			checkTile("ddrDataOut", wrDataSeen, expData);
		end
		else
		begin
			runRequest(opm, addr, wrData);
			if (timedOut)
			begin
				$display("timeout: %0s saw no okOk within %0d cycles", testName, timeoutCycles);
				errorCount++;
				testFailed = 1'b1;
				stopRun = 1'b1;
			end
			else
			begin
				checkOk("memOk", okSeen, expOk);
				if (opm == memPkg::opmRdTile && expOk == memPkg::okOk)
					checkTile("memDataOut", rdData, expData);
				checkCount("ddrCommands", cmds, expCmds);
				if (expLat != 0)
					checkCount("okLatency", cycles, expLat);
			end
		end
		reportTest(testName);
	endtask

	initial
	begin
		memOpm = memPkg::opmReady;
		memAddr = '0;
		memDataIn = '0;
		rstN = 1'b0;
		repeat (8) @(posedge clock);
		#5;
		rstN = 1'b1;
		@(posedge clock);
		#5;

		testFailed = 1'b0;
		checkOk("memOk", memOk, memPkg::okReady);
		checkOpm("ddrOpm", ddrOpm, memPkg::opmReady);
		reportTest("afterReset");

		fd = $fopen("bench/cacheInput.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file bench/cacheInput.txt");
			errorCount++;
		end
		else
		begin
			while (!stopRun && $fgets(lineBuf, fd) != 0)
			begin
				fields = $sscanf(lineBuf, "%s %h %h %h %h %h %h %h", testName, opm, addr,
					wrData, expData, expOk, expCmds, expLat);
				if (fields == 8)
					runLine();
			end
			$fclose(fd);
		end

		testFailed = 1'b0;
		checkCount("holdErrors", holdErrors, 0);
		$display("DDR hold cycles seen: %0d", holdCycles);
		reportTest("ddrHold");

		$display("%0d tests, %0d failed, %0d errors", testCount, failCount, errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== bench/ddrTileModel.sv ====
`timescale 1ns/1ps

module ddrTileModel (
	input logic clock,
	input logic rstN,
	input memPkg::byteAddrT ddrAddr,
	input memPkg::opmT ddrOpm,
	input memPkg::tileT ddrDataOut,
	input logic [1:0] holdPick,
	output memPkg::tileT ddrDataIn,
	output memPkg::okT ddrOk,
	output memPkg::byteAddrT lastWrAddr,
	output memPkg::tileT lastWrData
);

	localparam int maxTiles = 64;

	// sparse store, only tiles written by the cache are kept
	memPkg::byteAddrT keptAddr [maxTiles];
	memPkg::tileT keptTile [maxTiles];
	int keptCount = 0;
	logic [1:0] holdLeft;

	// unwritten tiles read back as a pattern of their own address
	function automatic memPkg::tileT readTile(input memPkg::byteAddrT addr);
		memPkg::tileT found;
		int i;
		found = {addr, ~addr, addr, ~addr};
		for (i = 0; i < keptCount; i++)
		begin
			if (keptAddr[i] == addr)
				found = keptTile[i];
		end
		return found;
	endfunction

	task automatic writeTile(input memPkg::byteAddrT addr, input memPkg::tileT data);
		int i;
		int slot;
		slot = keptCount;
		for (i = 0; i < keptCount; i++)
		begin
			if (keptAddr[i] == addr)
				slot = i;
		end
		keptAddr[slot] = addr;
		keptTile[slot] = data;
		if (slot == keptCount)
			keptCount++;
	endtask

	task finishCommand;
		ddrOk <= memPkg::okOk;
		if (ddrOpm == memPkg::opmWrTile)
		begin
			writeTile(ddrAddr, ddrDataOut);
			lastWrAddr <= ddrAddr;
			lastWrData <= ddrDataOut;
		end
		else
			ddrDataIn <= readTile(ddrAddr);
	endtask

	// ready, then 0 to 3 hold cycles, then one ok cycle
	always @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			ddrOk <= memPkg::okReady;
			holdLeft <= 2'd0;
			ddrDataIn <= '0;
			lastWrAddr <= '0;
			lastWrData <= '0;
		end
		else if (ddrOk == memPkg::okReady)
		begin
			if (ddrOpm != memPkg::opmReady)
			begin
				if (holdPick == 2'd0)
					finishCommand();
				else
				begin
					ddrOk <= memPkg::okHold;
					holdLeft <= holdPick - 2'd1;
				end
			end
		end
		else if (ddrOk == memPkg::okHold)
		begin
			if (holdLeft == 2'd0)
				finishCommand();
			else
				holdLeft <= holdLeft - 2'd1;
		end
		else
			ddrOk <= memPkg::okReady;
	end

endmodule

// ==== logic/l2TileCache.sv ====
`timescale 1ns/1ps

module l2TileCache #(
	parameter int indexBits = 10
) (
	input logic clock,
	input logic rstN,

	input memPkg::byteAddrT memAddr,
	input memPkg::opmT memOpm,
	input memPkg::tileT memDataIn,
	output memPkg::tileT memDataOut,
	output memPkg::okT memOk,

	output memPkg::byteAddrT ddrAddr,
	output memPkg::opmT ddrOpm,
	output memPkg::tileT ddrDataOut,
	input memPkg::tileT ddrDataIn,
	input memPkg::okT ddrOk
);

	// registered request and the line read for it
	memPkg::tileAddrT reqAddr;
	memPkg::opmT reqOpm;
	memPkg::tileT reqData;
	memPkg::tileT lineData;
	memPkg::tileAddrT lineTag;
	logic lineValid;
	logic lineDirty;

	// store port back into the arrays
	logic stall;
	logic storeEn;
	memPkg::tileAddrT storeTag;
	memPkg::tileT storeData;
	logic storeDirty;

	// miss handling
	logic missReq;
	logic victimDirty;
	memPkg::tileAddrT victimTag;
	memPkg::tileT victimData;
	logic fillDone;
	memPkg::tileT fillData;

	tileLookupStage #(
		.indexBits(indexBits)
	) lookup (
		.clock(clock),
		.rstN(rstN),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.memDataIn(memDataIn),
		.stall(stall),
		.storeEn(storeEn),
		.storeTag(storeTag),
		.storeData(storeData),
		.storeDirty(storeDirty),
		.reqAddr(reqAddr),
		.reqOpm(reqOpm),
		.reqData(reqData),
		.lineData(lineData),
		.lineTag(lineTag),
		.lineValid(lineValid),
		.lineDirty(lineDirty)
	);

	tileHitStage hit (
		.reqAddr(reqAddr),
		.reqOpm(reqOpm),
		.reqData(reqData),
		.lineData(lineData),
		.lineTag(lineTag),
		.lineValid(lineValid),
		.lineDirty(lineDirty),
		.fillDone(fillDone),
		.fillData(fillData),
		.stall(stall),
		.storeEn(storeEn),
		.storeTag(storeTag),
		.storeData(storeData),
		.storeDirty(storeDirty),
		.missReq(missReq),
		.victimDirty(victimDirty),
		.victimTag(victimTag),
		.victimData(victimData),
		.memDataOut(memDataOut),
		.memOk(memOk)
	);

	tileRefillSeq refill (
		.clock(clock),
		.rstN(rstN),
		.missReq(missReq),
		.reqOpm(reqOpm),
		.reqAddr(reqAddr),
		.victimDirty(victimDirty),
		.victimTag(victimTag),
		.victimData(victimData),
		.ddrDataIn(ddrDataIn),
		.ddrOk(ddrOk),
		.ddrAddr(ddrAddr),
		.ddrOpm(ddrOpm),
		.ddrDataOut(ddrDataOut),
		.fillDone(fillDone),
		.fillData(fillData)
	);

endmodule

// ==== logic/tileRefillSeq.sv ====
`timescale 1ns/1ps

module tileRefillSeq (
	input logic clock,
	input logic rstN,

	input logic missReq,
	input memPkg::opmT reqOpm,
	input memPkg::tileAddrT reqAddr,

	input logic victimDirty,
	input memPkg::tileAddrT victimTag,
	input memPkg::tileT victimData,

	input memPkg::tileT ddrDataIn,
	input memPkg::okT ddrOk,
	output memPkg::byteAddrT ddrAddr,
	output memPkg::opmT ddrOpm,
	output memPkg::tileT ddrDataOut,

	output logic fillDone,
	output memPkg::tileT fillData
);

	memPkg::refillStateT state;

	logic ddrIdle;
	logic ddrDone;
	logic startWb;
	logic captureFill;

	assign ddrIdle = (ddrOk == memPkg::okReady);
	assign ddrDone = (ddrOk == memPkg::okOk);
	assign startWb = (state == memPkg::idle) && missReq && ddrIdle && victimDirty;
	assign captureFill = (state == memPkg::fill) && (ddrOpm == memPkg::opmRdTile) && ddrDone;
	assign fillDone = (state == memPkg::install);

	// *************************************************************************
	// FSM and DDR command
	// *************************************************************************

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= memPkg::idle;
			ddrOpm <= memPkg::opmReady;
			ddrAddr <= '0;
		end
		else
		begin
			case (state)
				memPkg::idle:
				begin
					if (missReq && ddrIdle)
					begin
						if (victimDirty)
						begin
							ddrOpm <= memPkg::opmWrTile;
							ddrAddr <= {victimTag, 4'h0};
							state <= memPkg::writeBack;
						end
						else
						begin
							ddrOpm <= memPkg::opmRdTile;
							ddrAddr <= {reqAddr, 4'h0};
							state <= memPkg::fill;
						end
					end
				end
				memPkg::writeBack:
				begin
					if (ddrDone)
					begin
						ddrOpm <= memPkg::opmReady;
						// a write only needed the victim out of the way
						if (reqOpm == memPkg::opmWrTile)
							state <= memPkg::install;
						else
							state <= memPkg::fill;
					end
				end
				memPkg::fill:
				begin
					if (ddrOpm == memPkg::opmReady)
					begin
						// after a writeback, wait for the port to go idle again
						if (ddrIdle)
						begin
							ddrOpm <= memPkg::opmRdTile;
							ddrAddr <= {reqAddr, 4'h0};
						end
					end
					else if (ddrDone)
					begin
						ddrOpm <= memPkg::opmReady;
						state <= memPkg::install;
					end
				end
				memPkg::install:
				begin
					state <= memPkg::idle;
				end
				default:
				begin
					state <= memPkg::idle;
				end
			endcase
		end
	end

	// payload, victim out on writeback and tile in on fill
	always_ff @(posedge clock)
	begin
		if (startWb)
		begin
			ddrDataOut <= victimData;
			fillData <= victimData;
		end
		if (captureFill)
			fillData <= ddrDataIn;
	end

	// DDR back-pressure must not disturb a command in flight
	holdKeepsCommand: assert property (@(posedge clock) disable iff (!rstN)
		(ddrOk == memPkg::okHold) |=> ($stable(ddrOpm) && $stable(ddrAddr)));

endmodule

// ==== logic/tileHitStage.sv ====
`timescale 1ns/1ps

module tileHitStage (
	input memPkg::tileAddrT reqAddr,
	input memPkg::opmT reqOpm,
	input memPkg::tileT reqData,

	input memPkg::tileT lineData,
	input memPkg::tileAddrT lineTag,
	input logic lineValid,
	input logic lineDirty,

	input logic fillDone,
	input memPkg::tileT fillData,

	output logic stall,
	output logic storeEn,
	output memPkg::tileAddrT storeTag,
	output memPkg::tileT storeData,
	output logic storeDirty,

	output logic missReq,
	output logic victimDirty,
	output memPkg::tileAddrT victimTag,
	output memPkg::tileT victimData,

	output memPkg::tileT memDataOut,
	output memPkg::okT memOk
);

	logic addrIsRam;
	logic isRead;
	logic isWrite;
	logic access;
	logic tagHit;
	logic victimBlocks;

	// RAM region: tile bits 27:26 zero, 25:20 nonzero
	assign addrIsRam = (reqAddr[27:26] == 2'b00) && (reqAddr[25:20] != 6'h00);
	assign isRead = (reqOpm == memPkg::opmRdTile);
	assign isWrite = (reqOpm == memPkg::opmWrTile);
	assign access = addrIsRam && (isRead || isWrite);

	assign tagHit = lineValid && (lineTag == reqAddr);
	assign victimDirty = lineValid && lineDirty;
	// a dirty line of another tile must go out before this one moves in
	assign victimBlocks = victimDirty && !tagHit;

	assign victimTag = lineTag;
	assign victimData = lineData;
	assign memDataOut = lineData;

	// *************************************************************************
	// opm decode and response
	// *************************************************************************

	always_comb
	begin
		stall = 1'b0;
		missReq = 1'b0;
		storeEn = 1'b0;
		storeTag = reqAddr;
		storeData = reqData;
		storeDirty = 1'b0;
		memOk = memPkg::okReady;

		if (fillDone)
		begin
			// read: install the new tile. write: keep the victim, now clean
			stall = 1'b1;
			storeEn = 1'b1;
			storeTag = isWrite ? lineTag : reqAddr;
			storeData = fillData;
			memOk = memPkg::okHold;
		end
		else if (access && isRead)
		begin
			if (tagHit)
			begin
				memOk = memPkg::okOk;
			end
			else
			begin
				stall = 1'b1;
				missReq = 1'b1;
				memOk = memPkg::okHold;
			end
		end
		else if (access && isWrite)
		begin
			if (victimBlocks)
			begin
				stall = 1'b1;
				missReq = 1'b1;
				memOk = memPkg::okHold;
			end
			else
			begin
				// whole tile is written, no fill needed
				storeEn = 1'b1;
				storeDirty = 1'b1;
				memOk = memPkg::okOk;
			end
		end
	end

endmodule

// ==== logic/tileLookupStage.sv ====
`timescale 1ns/1ps

module tileLookupStage #(
	parameter int indexBits = 10
) (
	input logic clock,
	input logic rstN,

	input memPkg::byteAddrT memAddr,
	input memPkg::opmT memOpm,
	input memPkg::tileT memDataIn,

	input logic stall,
	input logic storeEn,
	input memPkg::tileAddrT storeTag,
	input memPkg::tileT storeData,
	input logic storeDirty,

	output memPkg::tileAddrT reqAddr,
	output memPkg::opmT reqOpm,
	output memPkg::tileT reqData,

	output memPkg::tileT lineData,
	output memPkg::tileAddrT lineTag,
	output logic lineValid,
	output logic lineDirty
);

	localparam int numLines = 2 ** indexBits;

	// *************************************************************************
	// line arrays, one tile per line
	// *************************************************************************

	memPkg::tileT dataArray [numLines];
	memPkg::tileAddrT tagArray [numLines];
	logic dirtyArray [numLines];
	// valid bits live in a flop vector so reset can clear them all at once
	logic [numLines-1:0] validVec;

	logic [indexBits-1:0] inIndex;
	logic [indexBits-1:0] heldIndex;
	logic [indexBits-1:0] readIndex;
	logic storeHitsRead;

	assign inIndex = memAddr[indexBits+3:4];
	assign heldIndex = reqAddr[indexBits-1:0];
	// while stalled keep re-reading the line of the held request
	assign readIndex = stall ? heldIndex : inIndex;
	// a store to the line being read is forwarded, so back to back requests see it
	assign storeHitsRead = storeEn && (readIndex == heldIndex);

	// *************************************************************************
	// request register
	// *************************************************************************

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			reqAddr <= '0;
			reqOpm <= memPkg::opmReady;
		end
		else if (!stall)
		begin
			reqAddr <= memAddr[31:4];
			reqOpm <= memOpm;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!stall)
			reqData <= memDataIn;
	end

	// *************************************************************************
	// array write and synchronous read
	// *************************************************************************

	always_ff @(posedge clock)
	begin
		if (storeEn)
		begin
			dataArray[heldIndex] <= storeData;
			tagArray[heldIndex] <= storeTag;
			dirtyArray[heldIndex] <= storeDirty;
		end
	end

	always_ff @(posedge clock)
	begin
		if (storeHitsRead)
		begin
			lineData <= storeData;
			lineTag <= storeTag;
			lineDirty <= storeDirty;
		end
		else
		begin
			lineData <= dataArray[readIndex];
			lineTag <= tagArray[readIndex];
			lineDirty <= dirtyArray[readIndex];
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			validVec <= '0;
			lineValid <= 1'b0;
		end
		else
		begin
			if (storeEn)
				validVec[heldIndex] <= 1'b1;
			lineValid <= storeHitsRead || validVec[readIndex];
		end
	end

	// the hit stage only stores on behalf of a request that is still live
	storeNeedsRequest: assert property (@(posedge clock) disable iff (!rstN)
		storeEn |-> (reqOpm != memPkg::opmReady));

endmodule

// ==== logic/memPkg.sv ====
package memPkg;

	// *************************************************************************
	// widths with a meaning
	// *************************************************************************

	typedef logic [127:0] tileT;
	typedef logic [31:0] byteAddrT;
	// byte address without its low 4 bits, also stored as the tag
	typedef logic [27:0] tileAddrT;
	typedef logic [4:0] opmT;
	typedef logic [1:0] okT;

	// *************************************************************************
	// bus codes, shared by the request side and the DDR side
	// *************************************************************************

	localparam opmT opmReady = 5'b00000;
	localparam opmT opmRdTile = 5'b10111;
	localparam opmT opmWrTile = 5'b11111;

	localparam okT okReady = 2'b00;
	localparam okT okOk = 2'b01;
	localparam okT okHold = 2'b10;

	// refill sequencer
	typedef enum logic [1:0]
	{
		idle,
		writeBack,
		fill,
		install
	} refillStateT;

endpackage
